// File: src/rv_pkg.sv
//********************
// Shared types and sizes for the RV32I subset core
// Word-only memories, 64 words each
// Instruction word zero decodes as a bubble
//********************
package rv_pkg;

	// Datapath and memory sizes
	localparam int XLEN       = 32;
	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;
	localparam int IMEM_AW    = $clog2(IMEM_WORDS);
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	// Major opcodes the decoder knows
	localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
	localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;

	typedef logic [4:0] reg_idx_t;

	// Instruction formats, MSB first
	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	// One word, five views
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
	} instr_u;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_IMM} wb_sel_e;

	typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

	// All zero is a bubble
	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		wb_sel_e wb_sel;
		alu_op_e alu_op;
		logic    alu_src_imm;
		logic    branch;
		logic    branch_ne;
	} ctrl_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		instr_u          instr;
	} if_id_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] rs1_val;
		logic [XLEN-1:0] rs2_val;
		logic [XLEN-1:0] imm;
		reg_idx_t        rs1;
		reg_idx_t        rs2;
		reg_idx_t        rd;
		ctrl_t           ctrl;
	} id_ex_t;

	typedef struct packed {
		logic [XLEN-1:0] alu_result;
		logic [XLEN-1:0] store_data;
		logic [XLEN-1:0] imm;
		reg_idx_t        rd;
		ctrl_t           ctrl;
	} ex_mem_t;

	typedef struct packed {
		logic [XLEN-1:0] alu_result;
		logic [XLEN-1:0] mem_data;
		logic [XLEN-1:0] imm;
		reg_idx_t        rd;
		ctrl_t           ctrl;
	} mem_wb_t;

	typedef struct packed {
		logic            reg_write;
		reg_idx_t        rd;
		logic [XLEN-1:0] data;
	} wb_t;

	typedef struct packed {
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] data;
	} store_evt_t;

endpackage

// File: src/rv_control.sv
//********************
// Decode, hazard and forwarding control
// Unsupported encodings become bubbles
// Only one load-use stall cycle is inserted
//********************
`timescale 1ns/10ps

module rv_control (
	input  rv_pkg::instr_u   i_instr,
	// Sources of the instruction in execute
	input  rv_pkg::reg_idx_t i_id_rs1,
	input  rv_pkg::reg_idx_t i_id_rs2,
	input  rv_pkg::reg_idx_t i_ex_rd,
	input  rv_pkg::ctrl_t    i_ex_ctrl,
	input  rv_pkg::reg_idx_t i_mem_rd,
	input  rv_pkg::ctrl_t    i_mem_ctrl,
	input  rv_pkg::wb_t      i_wb,
	input  logic             i_branch_taken,
	output rv_pkg::ctrl_t    o_ctrl,
	output logic             o_stall,
	output logic             o_flush,
	output rv_pkg::fwd_sel_e o_fwd_a,
	output rv_pkg::fwd_sel_e o_fwd_b
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       uses_rs1;
	logic       uses_rs2;

	assign opcode = i_instr.r_fmt.opcode;
	assign funct3 = i_instr.r_fmt.funct3;
	assign funct7 = i_instr.r_fmt.funct7;

	// Control bundle per opcode
	always_comb begin
		o_ctrl = '0;
		case (opcode)
			rv_pkg::OPC_RTYPE: begin
				o_ctrl.reg_write = 1'b1;
				case (funct3)
					3'b000: o_ctrl.alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
					3'b111: o_ctrl.alu_op = rv_pkg::ALU_AND;
					3'b110: o_ctrl.alu_op = rv_pkg::ALU_OR;
					3'b100: o_ctrl.alu_op = rv_pkg::ALU_XOR;
					3'b010: o_ctrl.alu_op = rv_pkg::ALU_SLT;
					// Shifts and sltu not supported
					default: o_ctrl = '0;
				endcase
			end
			rv_pkg::OPC_ITYPE: begin
				// addi only
				o_ctrl.reg_write   = (funct3 == 3'b000);
				o_ctrl.alu_src_imm = 1'b1;
			end
			rv_pkg::OPC_LOAD: begin
				// lw only
				o_ctrl.reg_write   = (funct3 == 3'b010);
				o_ctrl.mem_read    = (funct3 == 3'b010);
				o_ctrl.wb_sel      = rv_pkg::WB_MEM;
				o_ctrl.alu_src_imm = 1'b1;
			end
			rv_pkg::OPC_STORE: begin
				o_ctrl.mem_write   = (funct3 == 3'b010);
				o_ctrl.alu_src_imm = 1'b1;
			end
			rv_pkg::OPC_BRANCH: begin
				// beq is 000, bne is 001
				o_ctrl.branch    = (funct3[2:1] == 2'b00);
				o_ctrl.branch_ne = funct3[0];
			end
			rv_pkg::OPC_LUI: begin
				o_ctrl.reg_write   = 1'b1;
				o_ctrl.wb_sel      = rv_pkg::WB_IMM;
				o_ctrl.alu_op      = rv_pkg::ALU_PASS_B;
				o_ctrl.alu_src_imm = 1'b1;
			end
			default: o_ctrl = '0;
		endcase
	end

	// Which source fields are real registers
	assign uses_rs1 = (opcode == rv_pkg::OPC_RTYPE) || (opcode == rv_pkg::OPC_ITYPE) ||
		(opcode == rv_pkg::OPC_LOAD) || (opcode == rv_pkg::OPC_STORE) ||
		(opcode == rv_pkg::OPC_BRANCH);
	assign uses_rs2 = (opcode == rv_pkg::OPC_RTYPE) || (opcode == rv_pkg::OPC_STORE) ||
		(opcode == rv_pkg::OPC_BRANCH);

	// Load in execute feeding the instruction in decode
	assign o_stall = i_ex_ctrl.mem_read && (i_ex_rd != '0) &&
		((uses_rs1 && (i_ex_rd == i_instr.r_fmt.rs1)) ||
		 (uses_rs2 && (i_ex_rd == i_instr.r_fmt.rs2)));

	// Branch resolved in execute kills the two younger slots
	assign o_flush = i_branch_taken;

	// Memory stage wins over writeback, x0 never forwarded
	function automatic rv_pkg::fwd_sel_e pick_fwd(input rv_pkg::reg_idx_t rs);
		if (i_mem_ctrl.reg_write && !i_mem_ctrl.mem_read && (i_mem_rd != '0) && (i_mem_rd == rs))
			return rv_pkg::FWD_MEM;
		else if (i_wb.reg_write && (i_wb.rd != '0) && (i_wb.rd == rs))
			return rv_pkg::FWD_WB;
		else
			return rv_pkg::FWD_REG;
	endfunction

	assign o_fwd_a = pick_fwd(i_id_rs1);
	assign o_fwd_b = pick_fwd(i_id_rs2);

endmodule

// File: src/rv_fetch.sv
//********************
// PC and instruction memory
// PC sits at zero until i_start goes high
// Program is written word by word on the load port
//********************
`timescale 1ns/10ps

module rv_fetch (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_start,
	input  logic                       i_stall,
	input  logic                       i_flush,
	input  logic [rv_pkg::XLEN-1:0]    i_target,
	input  logic                       i_imem_wr,
	input  logic [rv_pkg::IMEM_AW-1:0] i_imem_addr,
	input  logic [rv_pkg::XLEN-1:0]    i_imem_data,
	output rv_pkg::if_id_t             o_if_id
);

	logic [rv_pkg::XLEN-1:0] imem [rv_pkg::IMEM_WORDS];
	logic [rv_pkg::XLEN-1:0] pc;
	logic [rv_pkg::XLEN-1:0] instr;

	// Boot loader write
	always_ff @(posedge i_clk) begin
		if (i_imem_wr)
			imem[i_imem_addr] <= i_imem_data;
	end

	// Asynchronous read indexed by the PC word address
	assign instr = imem[pc[rv_pkg::IMEM_AW+1:2]];

	// Redirect beats stall
	always_ff @(posedge i_clk) begin
		if (i_rst)
			pc <= '0;
		else if (i_flush)
			pc <= i_target;
		else if (i_start && !i_stall)
			pc <= pc + 32'd4;
	end

	// IF/ID clears to the all-zero bubble word
	always_ff @(posedge i_clk) begin
		if (i_rst || i_flush) begin
			o_if_id.instr <= '0;
		end else if (!i_stall) begin
			o_if_id.pc    <= pc;
			o_if_id.instr <= i_start ? instr : '0;
		end
	end

	// A load and a taken branch never sit in execute together
	a_no_stall_on_flush: assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_flush && i_stall));

endmodule

// File: src/rv_decode.sv
//********************
// Register file, immediates and ID/EX
// Registers have no reset so programs set what they read
// Writeback is visible to a read in the same cycle
//********************
`timescale 1ns/10ps

module rv_decode (
	input  logic             i_clk,
	input  logic             i_rst,
	input  rv_pkg::if_id_t   i_if_id,
	input  rv_pkg::ctrl_t    i_ctrl,
	input  logic             i_stall,
	input  logic             i_flush,
	input  rv_pkg::wb_t      i_wb,
	// Sources of the instruction now in execute
	output rv_pkg::reg_idx_t o_rs1,
	output rv_pkg::reg_idx_t o_rs2,
	output rv_pkg::id_ex_t   o_id_ex
);

	logic [rv_pkg::XLEN-1:0] regs [32];
	logic [rv_pkg::XLEN-1:0] imm;
	rv_pkg::instr_u          ins;

	assign ins = i_if_id.instr;

	// x0 is never written
	always_ff @(posedge i_clk) begin
		if (i_wb.reg_write && (i_wb.rd != '0))
			regs[i_wb.rd] <= i_wb.data;
	end

	// Read with writeback bypass
	function automatic logic [rv_pkg::XLEN-1:0] read_reg(input rv_pkg::reg_idx_t idx);
		if (idx == '0)
			return '0;
		else if (i_wb.reg_write && (i_wb.rd == idx))
			return i_wb.data;
		else
			return regs[idx];
	endfunction

	// Sign-extended immediate per format
	always_comb begin
		case (ins.r_fmt.opcode)
			rv_pkg::OPC_ITYPE,
			rv_pkg::OPC_LOAD:
				imm = {{20{ins.i_fmt.imm_11_0[11]}}, ins.i_fmt.imm_11_0};
			rv_pkg::OPC_STORE:
				imm = {{20{ins.s_fmt.imm_11_5[6]}}, ins.s_fmt.imm_11_5, ins.s_fmt.imm_4_0};
			rv_pkg::OPC_BRANCH:
				imm = {{19{ins.b_fmt.imm_12}}, ins.b_fmt.imm_12, ins.b_fmt.imm_11,
					ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};
			rv_pkg::OPC_LUI:
				imm = {ins.u_fmt.imm_31_12, 12'h000};
			default:
				imm = '0;
		endcase
	end

	// ID/EX clears only the control bundle for a bubble
	always_ff @(posedge i_clk) begin
		if (i_rst || i_stall || i_flush)
			o_id_ex.ctrl <= '0;
		else
			o_id_ex.ctrl <= i_ctrl;
		o_id_ex.pc      <= i_if_id.pc;
		o_id_ex.rs1_val <= read_reg(ins.r_fmt.rs1);
		o_id_ex.rs2_val <= read_reg(ins.r_fmt.rs2);
		o_id_ex.imm     <= imm;
		o_id_ex.rs1     <= ins.r_fmt.rs1;
		o_id_ex.rs2     <= ins.r_fmt.rs2;
		o_id_ex.rd      <= ins.r_fmt.rd;
	end

	assign o_rs1 = o_id_ex.rs1;
	assign o_rs2 = o_id_ex.rs2;

endmodule

// File: src/rv_execute.sv
//********************
// Execute stage and EX/MEM
// Branches resolve here with target PC plus immediate
// slt compares signed
//********************
`timescale 1ns/10ps

module rv_execute (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  rv_pkg::id_ex_t          i_id_ex,
	input  rv_pkg::fwd_sel_e        i_fwd_a,
	input  rv_pkg::fwd_sel_e        i_fwd_b,
	// ALU result held in EX/MEM
	input  logic [rv_pkg::XLEN-1:0] i_mem_fwd,
	input  rv_pkg::wb_t             i_wb,
	output logic                    o_branch_taken,
	output logic [rv_pkg::XLEN-1:0] o_target,
	output rv_pkg::ex_mem_t         o_ex_mem
);

	logic [rv_pkg::XLEN-1:0] op_a;
	logic [rv_pkg::XLEN-1:0] op_b_reg;
	logic [rv_pkg::XLEN-1:0] op_b;
	logic [rv_pkg::XLEN-1:0] alu_result;
	logic                    equal;

	// Forwarding muxes
	always_comb begin
		case (i_fwd_a)
			rv_pkg::FWD_MEM: op_a = i_mem_fwd;
			rv_pkg::FWD_WB:  op_a = i_wb.data;
			default:         op_a = i_id_ex.rs1_val;
		endcase
		case (i_fwd_b)
			rv_pkg::FWD_MEM: op_b_reg = i_mem_fwd;
			rv_pkg::FWD_WB:  op_b_reg = i_wb.data;
			default:         op_b_reg = i_id_ex.rs2_val;
		endcase
	end

	// Immediate after forwarding
	assign op_b = i_id_ex.ctrl.alu_src_imm ? i_id_ex.imm : op_b_reg;

	always_comb begin
		case (i_id_ex.ctrl.alu_op)
			rv_pkg::ALU_ADD: alu_result = op_a + op_b;
			rv_pkg::ALU_SUB: alu_result = op_a - op_b;
			rv_pkg::ALU_AND: alu_result = op_a & op_b;
			rv_pkg::ALU_OR:  alu_result = op_a | op_b;
			rv_pkg::ALU_XOR: alu_result = op_a ^ op_b;
			rv_pkg::ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
			// lui passes the immediate
			default:         alu_result = op_b;
		endcase
	end

	// beq or bne on forwarded registers
	assign equal          = (op_a == op_b_reg);
	assign o_branch_taken = i_id_ex.ctrl.branch && (i_id_ex.ctrl.branch_ne ? !equal : equal);
	assign o_target       = i_id_ex.pc + i_id_ex.imm;

	// EX/MEM
	always_ff @(posedge i_clk) begin
		if (i_rst)
			o_ex_mem.ctrl <= '0;
		else
			o_ex_mem.ctrl <= i_id_ex.ctrl;
		o_ex_mem.alu_result <= alu_result;
		// Store data must see forwarded rs2
		o_ex_mem.store_data <= op_b_reg;
		o_ex_mem.imm        <= i_id_ex.imm;
		o_ex_mem.rd         <= i_id_ex.rd;
	end

	// x0 operands reach execute as zero after register read and forwarding
	a_x0_zero: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_id_ex.ctrl != '0) |->
		((i_id_ex.rs1 != '0 || op_a == '0) &&
		 (i_id_ex.rs2 != '0 || op_b_reg == '0)));

endmodule

// File: src/rv_memory.sv
//********************
// Data memory, store port and MEM/WB
// Word accesses only, no reset on contents
// One store strobe per sw, no back-pressure
//********************
`timescale 1ns/10ps

module rv_memory (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  rv_pkg::ex_mem_t         i_ex_mem,
	output logic [rv_pkg::XLEN-1:0] o_mem_fwd,
	output logic                    o_store_valid,
	output rv_pkg::store_evt_t      o_store,
	output rv_pkg::wb_t             o_wb
);

	logic [rv_pkg::XLEN-1:0] dmem [rv_pkg::DMEM_WORDS];
	logic [rv_pkg::DMEM_AW-1:0] index;
	logic [rv_pkg::XLEN-1:0] mem_data;
	rv_pkg::mem_wb_t         mem_wb;

	// Byte address to word index
	assign index    = i_ex_mem.alu_result[rv_pkg::DMEM_AW+1:2];
	assign mem_data = dmem[index];

	always_ff @(posedge i_clk) begin
		if (i_ex_mem.ctrl.mem_write)
			dmem[index] <= i_ex_mem.store_data;
	end

	// Store event mirrors the write
	assign o_store_valid = i_ex_mem.ctrl.mem_write;
	assign o_store       = '{addr: i_ex_mem.alu_result, data: i_ex_mem.store_data};

	assign o_mem_fwd = i_ex_mem.alu_result;

	// MEM/WB
	always_ff @(posedge i_clk) begin
		if (i_rst)
			mem_wb.ctrl <= '0;
		else
			mem_wb.ctrl <= i_ex_mem.ctrl;
		mem_wb.alu_result <= i_ex_mem.alu_result;
		mem_wb.mem_data   <= mem_data;
		mem_wb.imm        <= i_ex_mem.imm;
		mem_wb.rd         <= i_ex_mem.rd;
	end

	// Writeback source
	always_comb begin
		o_wb.reg_write = mem_wb.ctrl.reg_write;
		o_wb.rd        = mem_wb.rd;
		case (mem_wb.ctrl.wb_sel)
			rv_pkg::WB_MEM: o_wb.data = mem_wb.mem_data;
			rv_pkg::WB_IMM: o_wb.data = mem_wb.imm;
			default:        o_wb.data = mem_wb.alu_result;
		endcase
	end

	// Addresses come from the ALU two stages back
	a_word_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_ex_mem.ctrl.mem_read || i_ex_mem.ctrl.mem_write) |->
		(i_ex_mem.alu_result[1:0] == 2'b00));

endmodule

// File: src/rv_core_top.sv
//********************
// Five-stage RV32I subset core
// Load the program while i_start is low
// Stores are seen only on the store port
//********************
`timescale 1ns/10ps

module rv_core_top (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_start,
	// Boot loader port
	input  logic                       i_imem_wr,
	input  logic [rv_pkg::IMEM_AW-1:0] i_imem_addr,
	input  logic [rv_pkg::XLEN-1:0]    i_imem_data,
	// Store observation port
	output logic                       o_store_valid,
	output rv_pkg::store_evt_t         o_store
);

	// Pipeline registers
	rv_pkg::if_id_t   if_id;
	rv_pkg::id_ex_t   id_ex;
	rv_pkg::ex_mem_t  ex_mem;
	rv_pkg::wb_t      wb;

	// Control and hazard wires
	rv_pkg::ctrl_t    ctrl;
	rv_pkg::fwd_sel_e fwd_a;
	rv_pkg::fwd_sel_e fwd_b;
	rv_pkg::reg_idx_t ex_rs1;
	rv_pkg::reg_idx_t ex_rs2;
	logic             stall;
	logic             flush;
	logic             branch_taken;
	logic [rv_pkg::XLEN-1:0] target;
	logic [rv_pkg::XLEN-1:0] mem_fwd;

	rv_control control0 (
		.i_instr        (if_id.instr),
		.i_id_rs1       (ex_rs1),
		.i_id_rs2       (ex_rs2),
		.i_ex_rd        (id_ex.rd),
		.i_ex_ctrl      (id_ex.ctrl),
		.i_mem_rd       (ex_mem.rd),
		.i_mem_ctrl     (ex_mem.ctrl),
		.i_wb           (wb),
		.i_branch_taken (branch_taken),
		.o_ctrl         (ctrl),
		.o_stall        (stall),
		.o_flush        (flush),
		.o_fwd_a        (fwd_a),
		.o_fwd_b        (fwd_b)
	);

	rv_fetch fetch0 (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_start     (i_start),
		.i_stall     (stall),
		.i_flush     (flush),
		.i_target    (target),
		.i_imem_wr   (i_imem_wr),
		.i_imem_addr (i_imem_addr),
		.i_imem_data (i_imem_data),
		.o_if_id     (if_id)
	);

	rv_decode decode0 (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_if_id (if_id),
		.i_ctrl  (ctrl),
		.i_stall (stall),
		.i_flush (flush),
		.i_wb    (wb),
		.o_rs1   (ex_rs1),
		.o_rs2   (ex_rs2),
		.o_id_ex (id_ex)
	);

	rv_execute execute0 (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_id_ex        (id_ex),
		.i_fwd_a        (fwd_a),
		.i_fwd_b        (fwd_b),
		.i_mem_fwd      (mem_fwd),
		.i_wb           (wb),
		.o_branch_taken (branch_taken),
		.o_target       (target),
		.o_ex_mem       (ex_mem)
	);

	rv_memory memory0 (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_ex_mem      (ex_mem),
		.o_mem_fwd     (mem_fwd),
		.o_store_valid (o_store_valid),
		.o_store       (o_store),
		.o_wb          (wb)
	);

endmodule

// File: verification/tb_rv_core_top.sv
//********************
// Testbench for rv_core_top
// Programs are built into a table at time zero
// Unused program slots are padded with the halt branch
// Data memory keeps its contents between programs
//********************
`timescale 1ns/10ps

module tb_rv_core_top;

	localparam int NUM_TESTS    = 6;
	localparam int PROG_WORDS   = 16;
	localparam int MAX_STORES   = 4;
	localparam int RESET_CYCLES = 2;
	localparam int RUN_CYCLES   = 40;
	localparam int TAIL_CYCLES  = 8;
	// Worst case of every test plus a little slack
	localparam int CYCLE_LIMIT  =
		NUM_TESTS * (RESET_CYCLES + PROG_WORDS + RUN_CYCLES + TAIL_CYCLES) + 10;

	// RV32I major opcodes used by the encoders
	localparam logic [6:0] OP_IMM  = 7'b0010011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;

	logic                       clk = 1'b0;
	logic                       rst;
	logic                       start;
	logic                       imem_wr;
	logic [rv_pkg::IMEM_AW-1:0] imem_addr;
	logic [rv_pkg::XLEN-1:0]    imem_data;
	logic                       store_valid;
	rv_pkg::store_evt_t         store;

	// Program table
	string              test_name [NUM_TESTS];
	logic [31:0]        prog      [NUM_TESTS][PROG_WORDS];
	int                 prog_len  [NUM_TESTS];
	rv_pkg::store_evt_t exp_store [NUM_TESTS][MAX_STORES];
	int                 exp_count [NUM_TESTS];
	int                 cur;

	int cycles;
	int errors;
	int test_errors;
	int passed;
	int failed;

	rv_core_top dut0 (
		.i_clk         (clk),
		.i_rst         (rst),
		.i_start       (start),
		.i_imem_wr     (imem_wr),
		.i_imem_addr   (imem_addr),
		.i_imem_data   (imem_data),
		.o_store_valid (store_valid),
		.o_store       (store)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	// Watchdog on total run length
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Result: FAILED");
		$finish;
	end

	// RV32I encoders with fields per the ISA formats
	function automatic logic [31:0] r_word(input int f7, input int f3, input int rd,
		input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] i_word(input logic [6:0] opc, input int f3, input int rd,
		input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	// sw only
	function automatic logic [31:0] s_word(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	// Offset in bytes relative to the branch
	function automatic logic [31:0] b_word(input int f3, input int rs1, input int rs2,
		input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0],
			off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_word(input int rd, input int imm20);
		return {imm20[19:0], rd[4:0], 7'b0110111};
	endfunction

	task automatic begin_test(input string name);
		cur++;
		test_name[cur] = name;
		prog_len[cur]  = 0;
		exp_count[cur] = 0;
	endtask

	task automatic add_instr(input logic [31:0] word);
		prog[cur][prog_len[cur]] = word;
		prog_len[cur]++;
	endtask

	task automatic expect_store(input logic [31:0] a, input logic [31:0] d);
		exp_store[cur][exp_count[cur]].addr = a;
		exp_store[cur][exp_count[cur]].data = d;
		exp_count[cur]++;
	endtask

	task automatic build_table();
		cur = -1;
		begin_test("alu_basic");
		add_instr(i_word(OP_IMM, 0, 1, 0, 7));       // addi x1, x0, 7
		add_instr(i_word(OP_IMM, 0, 2, 0, -3));      // addi x2, x0, -3
		add_instr(r_word(0, 0, 3, 1, 2));            // add  x3, x1, x2
		add_instr(r_word(32, 0, 4, 1, 2));           // sub  x4, x1, x2
		add_instr(r_word(0, 7, 5, 1, 2));            // and  x5, x1, x2
		add_instr(r_word(0, 6, 6, 1, 2));            // or   x6, x1, x2
		add_instr(s_word(3, 0, 0));                  // sw   x3, 0(x0)
		add_instr(s_word(4, 0, 4));
		add_instr(s_word(5, 0, 8));
		add_instr(s_word(6, 0, 12));
		expect_store(32'd0, 32'd7 + 32'hffff_fffd);
		expect_store(32'd4, 32'd7 - 32'hffff_fffd);
		expect_store(32'd8, 32'd7 & 32'hffff_fffd);
		expect_store(32'd12, 32'd7 | 32'hffff_fffd);

		begin_test("alu_slt_lui");
		add_instr(i_word(OP_IMM, 0, 1, 0, 7));
		add_instr(i_word(OP_IMM, 0, 2, 0, -3));
		add_instr(r_word(0, 4, 3, 1, 2));            // xor  x3, x1, x2
		add_instr(r_word(0, 2, 4, 2, 1));            // slt  x4, x2, x1
		add_instr(r_word(0, 2, 5, 1, 2));            // slt  x5, x1, x2
		add_instr(u_word(6, 32'h12345));             // lui  x6, 0x12345
		add_instr(s_word(3, 0, 16));
		add_instr(s_word(4, 0, 20));
		add_instr(s_word(5, 0, 24));
		add_instr(s_word(6, 0, 28));
		expect_store(32'd16, 32'd7 ^ 32'hffff_fffd);
		// Signed compare where -3 is less than 7
		expect_store(32'd20, 32'd1);
		expect_store(32'd24, 32'd0);
		expect_store(32'd28, 32'h1234_5000);

		begin_test("forwarding");
		add_instr(i_word(OP_IMM, 0, 1, 0, 5));       // addi x1, x0, 5
		add_instr(i_word(OP_IMM, 0, 2, 1, 3));       // addi x2, x1, 3
		add_instr(r_word(0, 0, 3, 2, 1));            // add  x3, x2, x1
		add_instr(r_word(32, 0, 4, 3, 2));           // sub  x4, x3, x2
		add_instr(s_word(4, 0, 32));                 // store data from memory stage
		add_instr(r_word(0, 0, 5, 4, 3));            // add  x5, x4, x3
		add_instr(s_word(5, 0, 36));
		add_instr(i_word(OP_IMM, 0, 7, 0, 64));      // addi x7, x0, 64
		add_instr(s_word(3, 7, 0));                  // base from memory stage
		add_instr(s_word(2, 7, 4));                  // base from writeback
		expect_store(32'd32, 32'd5);
		expect_store(32'd36, 32'd18);
		expect_store(32'd64, 32'd13);
		expect_store(32'd68, 32'd8);

		begin_test("load_use");
		add_instr(i_word(OP_IMM, 0, 1, 0, 21));      // addi x1, x0, 21
		add_instr(i_word(OP_IMM, 0, 2, 0, 80));      // addi x2, x0, 80
		add_instr(s_word(1, 2, 0));                  // sw   x1, 0(x2)
		add_instr(i_word(OP_LOAD, 2, 3, 2, 0));      // lw   x3, 0(x2)
		add_instr(r_word(0, 0, 4, 3, 1));            // add  x4, x3, x1
		add_instr(s_word(4, 2, 4));
		add_instr(i_word(OP_LOAD, 2, 5, 2, 4));      // lw   x5, 4(x2)
		add_instr(s_word(5, 2, 8));                  // store right after load
		add_instr(i_word(OP_LOAD, 2, 6, 2, 0));      // lw   x6, 0(x2)
		add_instr(r_word(0, 0, 7, 6, 4));            // add  x7, x6, x4
		add_instr(s_word(7, 2, 12));
		expect_store(32'd80, 32'd21);
		expect_store(32'd84, 32'd42);
		expect_store(32'd88, 32'd42);
		expect_store(32'd92, 32'd63);

		begin_test("branches");
		add_instr(i_word(OP_IMM, 0, 1, 0, 1));       // addi x1, x0, 1
		add_instr(i_word(OP_IMM, 0, 2, 0, 2));       // addi x2, x0, 2
		add_instr(b_word(0, 1, 1, 12));              // beq  x1, x1, taken
		add_instr(s_word(1, 0, 96));                 // skipped
		add_instr(s_word(1, 0, 100));                // skipped
		add_instr(b_word(1, 1, 2, 12));              // bne  x1, x2, taken
		add_instr(s_word(2, 0, 104));                // skipped
		add_instr(s_word(2, 0, 108));                // skipped
		add_instr(b_word(0, 1, 2, 8));               // beq  x1, x2, not taken
		add_instr(s_word(1, 0, 112));
		add_instr(b_word(1, 1, 1, 8));               // bne  x1, x1, not taken
		add_instr(s_word(2, 0, 116));
		add_instr(r_word(0, 0, 3, 1, 2));            // add  x3, x1, x2
		add_instr(s_word(3, 0, 120));
		expect_store(32'd112, 32'd1);
		expect_store(32'd116, 32'd2);
		expect_store(32'd120, 32'd3);

		begin_test("x0_and_mem");
		add_instr(i_word(OP_IMM, 0, 0, 0, 55));      // addi x0, x0, 55
		add_instr(s_word(0, 0, 128));                // x0 must store as zero
		add_instr(i_word(OP_IMM, 0, 1, 0, -1));      // addi x1, x0, -1
		add_instr(s_word(1, 0, 132));
		add_instr(i_word(OP_LOAD, 2, 2, 0, 132));    // lw   x2, 132(x0)
		add_instr(i_word(OP_LOAD, 2, 3, 0, 128));    // lw   x3, 128(x0)
		add_instr(r_word(32, 0, 4, 3, 2));           // sub  x4, x3, x2
		add_instr(s_word(4, 0, 136));
		add_instr(i_word(OP_LOAD, 2, 5, 0, 136));    // read back the last store
		add_instr(s_word(5, 0, 140));
		expect_store(32'd128, 32'd0);
		expect_store(32'd132, 32'hffff_ffff);
		expect_store(32'd136, 32'd0 - 32'hffff_ffff);
		expect_store(32'd140, 32'd1);
	endtask

	// One word per cycle on the boot port
	task automatic load_program(input int t);
		for (int i = 0; i < PROG_WORDS; i++) begin
			imem_wr   = 1'b1;
			imem_addr = i[rv_pkg::IMEM_AW-1:0];
			// Halt is beq x0, x0 to itself
			imem_data = (i < prog_len[t]) ? prog[t][i] : b_word(0, 0, 0, 0);
			@(negedge clk);
		end
		imem_wr = 1'b0;
	endtask

	task automatic check_store(input string name, input int idx,
		input rv_pkg::store_evt_t exp_evt, input rv_pkg::store_evt_t act_evt);
		if (act_evt !== exp_evt) begin
			$display("error: %s store %0d expected addr=%h data=%h actual addr=%h data=%h",
				name, idx, exp_evt.addr, exp_evt.data, act_evt.addr, act_evt.data);
			test_errors++;
		end
	endtask

	task automatic run_test(input int t);
		int seen;
		int waited;
		int extra;
		seen        = 0;
		waited      = 0;
		extra       = 0;
		test_errors = 0;
		// Core held in reset and not started
		rst   = 1'b1;
		start = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		load_program(t);
		start = 1'b1;
		// Outputs settle after the rising edge
		while (seen < exp_count[t] && waited < RUN_CYCLES) begin
			@(negedge clk);
			waited++;
			if (store_valid) begin
				check_store(test_name[t], seen, exp_store[t][seen], store);
				seen++;
			end
		end
		if (seen < exp_count[t]) begin
			$display("%s: only %0d of %0d stores seen within %0d cycles",
				test_name[t], seen, exp_count[t], RUN_CYCLES);
			test_errors++;
		end
		// Program now spins on its halt branch
		repeat (TAIL_CYCLES) begin
			@(negedge clk);
			if (store_valid)
				extra++;
		end
		if (extra != 0) begin
			$display("%s: %0d store strobes came after the last expected store",
				test_name[t], extra);
			test_errors++;
		end
		errors += test_errors;
		if (test_errors == 0)
			passed++;
		else
			failed++;
		$display("test %0d %s: %s", t, test_name[t], (test_errors == 0) ? "pass" : "fail");
	endtask

	initial begin
		rst       = 1'b1;
		start     = 1'b0;
		imem_wr   = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		errors    = 0;
		passed    = 0;
		failed    = 0;
		build_table();
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("tests: %0d  passed: %0d  failed: %0d  errors: %0d",
			NUM_TESTS, passed, failed, errors);
		if (failed == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: rv_core_top.f
src/rv_pkg.sv
src/rv_control.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_memory.sv
src/rv_core_top.sv
verification/tb_rv_core_top.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then judge the log
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_rv_core_top -f rv_core_top.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Result: PASSED" sim.log && echo "simulation ok" \
	|| { echo "simulation reported failure"; exit 1; }
